// ==== Makefile ====
# Verilator flow for the SECDED pipeline.

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= ecc_tb
LINT_TOP  ?= ecc_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)."; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "No result in $(LOG)."; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
source/ecc_pkg.sv
source/ecc_decode.sv
source/ecc_execute.sv
source/ecc_result.sv
source/ecc_top.sv
tb/ecc_sva.sv
tb/ecc_tb.sv

// ==== include/ecc_cfg.svh ====
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

// ##############################
// Word geometry
// ##############################

// Data bits per protected word.
`define ECC_DATA_WIDTH 122

// Check bits per word: 8 position bits plus one overall parity bit.
`define ECC_PARITY_WIDTH 9

// ##############################
// Flow control
// ##############################

// Result FIFO entries, also the upstream credits available after reset.
`define ECC_FIFO_DEPTH 4

// Credits the DUT holds towards downstream after reset.
`define ECC_OUT_CREDITS 2

`endif

// ==== source/ecc_decode.sv ====
`timescale 1ns/100ps

module ecc_decode
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      in_valid,
    input  data_t     in_data,
    input  parity_t   in_parity,
    input  ecc_op_e   in_op,
    output parity_t   in_parity_out,

    output logic      ex_valid,
    output data_t     ex_data,
    output syndrome_t ex_syndrome,
    output ecc_op_e   ex_op
);

    localparam int DATA_W = $bits(data_t);

    parity_t   enc_parity;
    syndrome_t syndrome;

    // ##############################
    // Encoder
    // ##############################

    // Each check bit is the XOR of the data bits whose column has it set.
    always_comb begin
        enc_parity = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (in_data[i]) begin
                enc_parity = enc_parity ^ ecc_column(i);
            end
        end
    end

    assign in_parity_out = enc_parity; // Same cycle, as seen by the producer.
    assign syndrome      = in_parity ^ enc_parity;

    // ##############################
    // Decode stage register
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= in_valid; // The pipeline never stalls.
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            ex_data     <= in_data;
            ex_syndrome <= syndrome;
            ex_op       <= in_op;
        end
    end

endmodule

// ==== source/ecc_execute.sv ====
`timescale 1ns/100ps

module ecc_execute
    import ecc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      ex_valid,
    input  data_t     ex_data,
    input  syndrome_t ex_syndrome,
    input  ecc_op_e   ex_op,

    output logic      rs_valid,
    output data_t     rs_data,
    output logic      rs_sbit,
    output logic      rs_dbit
);

    localparam int DATA_W = $bits(data_t);

    data_t      mask;
    logic       col_hit;
    ecc_class_e syn_class;
    data_t      fixed_data;
    logic       sbit;
    logic       dbit;

    // ##############################
    // Syndrome classification
    // ##############################

    // Compare the syndrome against every data column; at most one can match.
    always_comb begin
        mask    = '0;
        col_hit = 1'b0;
        for (int i = 0; i < DATA_W; i++) begin
            if (ex_syndrome == ecc_column(i)) begin
                mask[i] = 1'b1;
                col_hit = 1'b1;
            end
        end
    end

    always_comb begin
        if (ex_syndrome == '0) begin
            syn_class = CLASS_CLEAN;
        end else if ($onehot(ex_syndrome)) begin
            syn_class = CLASS_CHECK_ERR; // Only a check bit flipped.
        end else if (col_hit) begin
            syn_class = CLASS_DATA_ERR;
        end else begin
            syn_class = CLASS_UNCORR;
        end
    end

    // Bypassed words leave untouched and raise no flag.
    assign fixed_data = (ex_op == OP_BYPASS) ? ex_data : (ex_data ^ mask);
    assign sbit = (ex_op == OP_CORRECT) &&
                  ((syn_class == CLASS_CHECK_ERR) || (syn_class == CLASS_DATA_ERR));
    assign dbit = (ex_op == OP_CORRECT) && (syn_class == CLASS_UNCORR);

    // ##############################
    // Execute stage register
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs_valid <= 1'b0;
        end else begin
            rs_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            rs_data <= fixed_data;
            rs_sbit <= sbit;
            rs_dbit <= dbit;
        end
    end

endmodule

// ==== source/ecc_pkg.sv ====
`include "ecc_cfg.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0]   data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] parity_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] syndrome_t;

    // Per-word opcode.
    typedef enum logic [0:0] {
        OP_CORRECT = 1'b0,
        OP_BYPASS  = 1'b1
    } ecc_op_e;

    // Syndrome classification.
    typedef enum logic [1:0] {
        CLASS_CLEAN     = 2'd0,
        CLASS_CHECK_ERR = 2'd1,
        CLASS_DATA_ERR  = 2'd2,
        CLASS_UNCORR    = 2'd3
    } ecc_class_e;

    // ##############################
    // Parity check matrix columns
    // ##############################

    // Data bit idx maps onto the (idx+1)-th value of 3, 5, 6, 7, 9, ...
    // that is not a power of two. Bits 7..0 of the column hold that value
    // and bit 8 brings the column weight up to an odd number.
    function automatic syndrome_t ecc_column(input int unsigned idx);
        int unsigned n;
        int unsigned v;
        logic [7:0]  pos;
        syndrome_t   col;
        n   = 0;
        pos = '0;
        for (v = 3; v <= 130; v++) begin
            if ((v & (v - 1)) != 0) begin // Powers of two belong to check bits.
                if (n == idx) begin
                    pos = v[7:0];
                end
                n++;
            end
        end
        col[7:0] = pos;
        col[8]   = ~(^pos); // Odd column weight for double error detection.
        return col;
    endfunction

endpackage

// ==== source/ecc_result.sv ====
`timescale 1ns/100ps
`include "ecc_cfg.svh"

module ecc_result
    import ecc_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  rs_valid,
    input  data_t rs_data,
    input  logic  rs_sbit,
    input  logic  rs_dbit,

    input  logic  out_credit,
    output logic  out_valid,
    output data_t out_data,
    output logic  out_sbit_err,
    output logic  out_dbit_err,
    output logic  in_credit
);

    localparam int DEPTH  = `ECC_FIFO_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`ECC_OUT_CREDITS + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    data_t             mem_data [DEPTH];
    logic [1:0]        mem_flags [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] out_cred_cnt;
    logic              empty;
    logic              pop;
    logic              fifo_pop;
    logic              push;

    assign empty    = (count == '0);
    assign pop      = (!empty || rs_valid) && (out_cred_cnt != '0);
    assign fifo_pop = pop && !empty;
    assign push     = rs_valid && !(empty && pop); // Empty FIFO lets the word straight through.

    // ##############################
    // FIFO control
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr]  <= rs_data;
            mem_flags[wr_ptr] <= {rs_dbit, rs_sbit};
        end
    end

    // ##############################
    // Credits and output register
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cred_cnt <= CRED_W'(`ECC_OUT_CREDITS);
            out_valid    <= 1'b0;
            in_credit    <= 1'b0;
        end else begin
            case ({pop, out_credit})
                2'b10:   out_cred_cnt <= out_cred_cnt - 1'b1;
                2'b01:   out_cred_cnt <= out_cred_cnt + 1'b1;
                default: out_cred_cnt <= out_cred_cnt;
            endcase
            out_valid <= pop;
            in_credit <= pop; // One slot freed for the producer per word sent.
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_data     <= empty ? rs_data : mem_data[rd_ptr];
            out_sbit_err <= empty ? rs_sbit : mem_flags[rd_ptr][0];
            out_dbit_err <= empty ? rs_dbit : mem_flags[rd_ptr][1];
        end
    end

endmodule

// ==== source/ecc_top.sv ====
`timescale 1ns/100ps

module ecc_top
    import ecc_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    in_valid,
    input  data_t   in_data,
    input  parity_t in_parity,
    input  ecc_op_e in_op,
    output parity_t in_parity_out,
    output logic    in_credit,

    input  logic    out_credit,
    output logic    out_valid,
    output data_t   out_data,
    output logic    out_sbit_err,
    output logic    out_dbit_err
);

    logic      ex_valid;
    data_t     ex_data;
    syndrome_t ex_syndrome;
    ecc_op_e   ex_op;

    logic      rs_valid;
    data_t     rs_data;
    logic      rs_sbit;
    logic      rs_dbit;

    // Encoder and syndrome.
    ecc_decode decode0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_parity     (in_parity),
        .in_op         (in_op),
        .in_parity_out (in_parity_out),
        .ex_valid      (ex_valid),
        .ex_data       (ex_data),
        .ex_syndrome   (ex_syndrome),
        .ex_op         (ex_op)
    );

    ecc_execute execute0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_valid    (ex_valid),
        .ex_data     (ex_data),
        .ex_syndrome (ex_syndrome),
        .ex_op       (ex_op),
        .rs_valid    (rs_valid),
        .rs_data     (rs_data),
        .rs_sbit     (rs_sbit),
        .rs_dbit     (rs_dbit)
    );

    // Result FIFO and both credit loops.
    ecc_result result0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs_valid     (rs_valid),
        .rs_data      (rs_data),
        .rs_sbit      (rs_sbit),
        .rs_dbit      (rs_dbit),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_sbit_err (out_sbit_err),
        .out_dbit_err (out_dbit_err),
        .in_credit    (in_credit)
    );

endmodule

// ==== tb/ecc_sva.sv ====
`timescale 1ns/100ps
`include "ecc_cfg.svh"

module ecc_sva #(
    parameter int CRED_W = $clog2(`ECC_OUT_CREDITS + 1),
    parameter int CNT_W  = $clog2(`ECC_FIFO_DEPTH + 1)
) (
    input logic              clk,
    input logic              rst_n,
    input logic              rs_valid,
    input logic              out_credit,
    input logic              out_valid,
    input logic              in_credit,
    input logic              push,
    input logic              fifo_pop,
    input logic [CRED_W-1:0] out_cred_cnt,
    input logic [CNT_W-1:0]  count
);

    logic            credit_d;
    logic [CRED_W:0] cred_model;
    logic [CNT_W:0]  held;

    // Port-level copies of both credit loops.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_d   <= 1'b0;
            cred_model <= (CRED_W + 1)'(`ECC_OUT_CREDITS);
            held       <= '0;
        end else begin
            credit_d   <= out_credit; // A returned credit is usable from the next edge.
            cred_model <= cred_model + (CRED_W + 1)'(credit_d)
                          - (CRED_W + 1)'(out_valid);
            held       <= held + (CNT_W + 1)'(rs_valid) - (CNT_W + 1)'(in_credit);
        end
    end

    cred_limit: assert property (@(posedge clk) disable iff (!rst_n)
        out_cred_cnt <= CRED_W'(`ECC_OUT_CREDITS))
        else $error("output credit count above its reset value");

    // Words sent never outrun the credits returned on the ports.
    valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (cred_model != '0))
        else $error("word sent while no output credit was held");

    fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(`ECC_FIFO_DEPTH))
        else $error("result FIFO count above its depth");

    // A full FIFO can take a word only while it also pops one.
    full_push: assert property (@(posedge clk) disable iff (!rst_n)
        (count == CNT_W'(`ECC_FIFO_DEPTH) && push) |-> fifo_pop)
        else $error("push into a full result FIFO");

    // Every input credit stands for a word that reached this stage.
    credit_on_pop: assert property (@(posedge clk) disable iff (!rst_n)
        in_credit |-> (held != '0))
        else $error("input credit returned without a word leaving the FIFO");

endmodule

bind ecc_result ecc_sva sva0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .rs_valid     (rs_valid),
    .out_credit   (out_credit),
    .out_valid    (out_valid),
    .in_credit    (in_credit),
    .push         (push),
    .fifo_pop     (fifo_pop),
    .out_cred_cnt (out_cred_cnt),
    .count        (count)
);

// ==== tb/ecc_tb.sv ====
`timescale 1ns/100ps
`include "ecc_cfg.svh"

module ecc_tb
    import ecc_pkg::*;
();

    localparam int DATA_W      = `ECC_DATA_WIDTH;
    localparam int CHECK_W     = `ECC_PARITY_WIDTH;
    localparam int NBITS       = DATA_W + CHECK_W;
    localparam int TOTAL_WORDS = 16 + 12 + 6 + 12 + 8 + 12;
    localparam int CYCLE_LIMIT = 20 * TOTAL_WORDS;

    typedef struct packed {
        data_t data;
        logic  sbit;
        logic  dbit;
    } expect_t;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    in_valid;
    data_t   in_data;
    parity_t in_parity;
    ecc_op_e in_op;
    parity_t in_parity_out;
    logic    in_credit;
    logic    out_credit;
    logic    out_valid;
    data_t   out_data;
    logic    out_sbit_err;
    logic    out_dbit_err;

    expect_t     exp_q[$];
    expect_t     mon_exp;
    logic [31:0] lfsr       = 32'h96cd_c21b;
    logic [31:0] cred_lfsr  = 32'h96cd_c21b; // Separate stream for the credit schedule.
    int          cycle_cnt  = 0;
    int          hold_until = 0;
    int          sent_cnt   = 0;
    int          in_cred_cnt = 0;
    int          rcv_cnt    = 0;
    int          ocred_cnt  = 0;
    int          check_cnt  = 0;
    int          err_cnt    = 0;
    int          test_chk0  = 0;
    int          test_err0  = 0;

    always #2 clk = ~clk;

    ecc_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_parity     (in_parity),
        .in_op         (in_op),
        .in_parity_out (in_parity_out),
        .in_credit     (in_credit),
        .out_credit    (out_credit),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_sbit_err  (out_sbit_err),
        .out_dbit_err  (out_dbit_err)
    );

    // ##############################
    // Random numbers and reference
    // ##############################

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_val(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_data(output data_t d);
        for (int i = 0; i < DATA_W; i++) begin
            lfsr = lfsr_step(lfsr);
            d[i] = lfsr[0];
        end
    endtask

    // Walk the non-powers of two from 3 upward until the idx-th one.
    function automatic parity_t ref_column(input int unsigned idx);
        int unsigned pos;
        int unsigned k;
        logic [7:0]  p8;
        pos = 2;
        k   = 0;
        while (k <= idx) begin
            pos++;
            if ((pos & (pos - 1)) != 0) begin
                k++;
            end
        end
        p8 = pos[7:0];
        return {~(^p8), p8};
    endfunction

    function automatic parity_t ref_parity(input data_t d);
        parity_t p;
        p = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (d[i]) begin
                p = p ^ ref_column(i);
            end
        end
        return p;
    endfunction

    function automatic expect_t ref_expect(input data_t d, input parity_t p, input ecc_op_e op);
        expect_t e;
        parity_t syn;
        e.data = d;
        e.sbit = 1'b0;
        e.dbit = 1'b0;
        syn    = p ^ ref_parity(d);
        if (op == OP_CORRECT && syn != '0) begin
            e.sbit = ($countones(syn) == 1); // A lone check bit.
            e.dbit = !e.sbit;
            for (int i = 0; i < DATA_W; i++) begin
                if (syn == ref_column(i)) begin
                    e.data[i] = ~e.data[i];
                    e.sbit    = 1'b1;
                    e.dbit    = 1'b0;
                end
            end
        end
        return e;
    endfunction

    // ##############################
    // Checks and stimulus
    // ##############################

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_parity(input string name, input parity_t got, input parity_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Positions from DATA_W upward are check bits.
    task automatic flip_bit(inout data_t d, inout parity_t p, input int b);
        if (b < DATA_W) begin
            d[b] = ~d[b];
        end else begin
            p[b - DATA_W] = ~p[b - DATA_W];
        end
    endtask

    // Called 1 ns after a rising edge and returns at the same phase.
    task automatic send_word(input data_t d, input parity_t p, input ecc_op_e op);
        while (sent_cnt - in_cred_cnt >= `ECC_FIFO_DEPTH) begin
            @(posedge clk);
            #1;
        end
        in_valid  = 1'b1;
        in_data   = d;
        in_parity = p;
        in_op     = op;
        exp_q.push_back(ref_expect(d, p, op));
        sent_cnt++;
        #0.5;
        check_parity("in_parity_out", in_parity_out, ref_parity(d));
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        $display("%-14s %0d checks, %0d errors", name, check_cnt - test_chk0,
                 err_cnt - test_err0);
        test_chk0 = check_cnt;
        test_err0 = err_cnt;
    endtask

    // Downstream returns a credit for a received word on random cycles.
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cred_lfsr = lfsr_step(cred_lfsr);
            if (cycle_cnt >= hold_until && rcv_cnt > ocred_cnt && cred_lfsr[0]) begin
                out_credit = 1'b1;
                ocred_cnt++;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    // Compare process.
    always @(negedge clk) begin
        if (in_credit) begin
            in_cred_cnt++;
        end
        if (out_valid) begin
            rcv_cnt++;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("ERROR at %0t: a word came out with none expected", $time);
            end else begin
                mon_exp = exp_q.pop_front();
                check_data("out_data", out_data, mon_exp.data);
                check_flag("out_sbit_err", out_sbit_err, mon_exp.sbit);
                check_flag("out_dbit_err", out_dbit_err, mon_exp.dbit);
            end
            if (rcv_cnt - ocred_cnt > `ECC_OUT_CREDITS) begin
                err_cnt++;
                $display("ERROR at %0t: more words out than output credits given", $time);
            end
        end
        if (in_cred_cnt > sent_cnt) begin
            err_cnt++;
            $display("ERROR at %0t: more input credits returned than words sent", $time);
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("ERROR: timeout after %0d cycles, %0d words missing", cycle_cnt, exp_q.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        data_t       d;
        parity_t     p;
        logic [31:0] r;
        int          a;
        int          b;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_parity = '0;
        in_op     = OP_CORRECT;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_credit", in_credit, 1'b0);

        for (int k = 0; k < 16; k++) begin
            rand_data(d);
            send_word(d, ref_parity(d), OP_CORRECT);
        end
        finish_test("clean");

        for (int k = 0; k < 12; k++) begin
            rand_data(d);
            p = ref_parity(d);
            rand_val(7, r);
            b = (k < 2) ? 120 + k : int'(r % 122); // Top two bits use columns 129 and 130.
            flip_bit(d, p, b);
            send_word(d, p, OP_CORRECT);
        end
        finish_test("data flip");

        for (int k = 0; k < 6; k++) begin
            rand_data(d);
            p = ref_parity(d);
            rand_val(4, r);
            flip_bit(d, p, DATA_W + int'(r % CHECK_W));
            send_word(d, p, OP_CORRECT);
        end
        finish_test("check flip");

        for (int k = 0; k < 12; k++) begin
            rand_data(d);
            p = ref_parity(d);
            rand_val(8, r);
            a = int'(r % NBITS);
            rand_val(8, r);
            b = (a + 1 + int'(r % (NBITS - 1))) % NBITS;
            flip_bit(d, p, a);
            flip_bit(d, p, b);
            send_word(d, p, OP_CORRECT);
        end
        finish_test("double flip");

        for (int k = 0; k < 8; k++) begin
            rand_data(d);
            p = ref_parity(d);
            rand_val(8, r);
            a = int'(r % NBITS);
            flip_bit(d, p, a);
            rand_val(1, r);
            if (r[0]) begin
                flip_bit(d, p, (a + 1) % NBITS);
            end
            send_word(d, p, OP_BYPASS);
        end
        finish_test("bypass");

        // Withhold output credits so that the FIFO fills up.
        @(negedge clk);
        hold_until = cycle_cnt + 40;
        @(posedge clk);
        #1;
        for (int k = 0; k < 12; k++) begin
            rand_data(d);
            p = ref_parity(d);
            rand_val(8, r);
            flip_bit(d, p, int'(r % NBITS));
            send_word(d, p, OP_CORRECT);
        end
        finish_test("back-pressure");

        $display("total: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
